// ==== dv/qdr_sram_model.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "qdr_bridge_params.svh"

module qdr_sram_model #(
  parameter int MEM_BITS = 6
) (
  input  wire logic                     qdr_clk,
  input  wire logic                     qdr_rst,
  input  wire qdr_bridge_pkg::qdr_req_t req,
  output qdr_bridge_pkg::qdr_rsp_t      rsp
);

  // two 72 bit beats per burst address
  logic [71:0]             mem [2**(MEM_BITS+1)];
  logic                    ack_q;
  logic                    busy;
  logic [31:0]             delay_cnt;
  logic                    wr_beat1;
  logic [MEM_BITS-1:0]     wr_addr;
  logic [MEM_BITS-1:0]     rd_addr;
  logic [`QDR_LATENCY-1:0] rd_sr;
  logic [71:0]             q_q;
  logic                    grant;

  initial begin
    for (int i = 0; i < 2**(MEM_BITS+1); i++) begin
      mem[i] = '0;
    end
  end

  // grant is the cycle where the port sees req and ack together
  assign grant = req.req & rsp.ack;

  always @(posedge qdr_clk) begin
    if (qdr_rst) begin
      ack_q     <= 1'b0;
      busy      <= 1'b0;
      delay_cnt <= '0;
      wr_beat1  <= 1'b0;
      wr_addr   <= '0;
      rd_addr   <= '0;
      rd_sr     <= '0;
      q_q       <= '0;
    end else begin
      rd_sr    <= {rd_sr[`QDR_LATENCY-2:0], grant & req.r};
      wr_beat1 <= grant & req.w;
      // random wait of 0 to 5 cycles before ack
      if (grant) begin
        ack_q <= 1'b0;
        busy  <= 1'b0;
      end else if (req.req && !busy) begin
        busy      <= 1'b1;
        delay_cnt <= $urandom % 6;
      end else if (busy && !ack_q) begin
        if (delay_cnt == 0) begin
          ack_q <= 1'b1;
        end else begin
          delay_cnt <= delay_cnt - 1;
        end
      end
      // beat 0 lanes in the grant cycle
      if (grant && req.w) begin
        wr_addr <= req.addr[MEM_BITS-1:0];
        for (int i = 0; i < 8; i++) begin
          if (req.be[i]) begin
            mem[{req.addr[MEM_BITS-1:0], 1'b0}][i*9 +: 9] <= req.d[i*9 +: 9];
          end
        end
      end
      // beat 1 lanes one cycle later
      if (wr_beat1) begin
        for (int i = 0; i < 8; i++) begin
          if (req.be[i]) begin
            mem[{wr_addr, 1'b1}][i*9 +: 9] <= req.d[i*9 +: 9];
          end
        end
      end
      if (grant && req.r) begin
        rd_addr <= req.addr[MEM_BITS-1:0];
      end
      // staged one edge early, the falling edge puts it on the bus
      if (rd_sr[`QDR_LATENCY-2]) begin
        q_q <= mem[{rd_addr, 1'b0}];
      end else if (rd_sr[`QDR_LATENCY-1]) begin
        q_q <= mem[{rd_addr, 1'b1}];
      end
    end
  end

  // bank outputs change on the falling edge
  always @(negedge qdr_clk) begin
    rsp.ack <= ack_q;
    rsp.q   <= q_q;
  end

endmodule

`default_nettype wire

// ==== dv/tb_qdr_cpu_bridge.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "qdr_bridge_params.svh"

module tb_qdr_cpu_bridge;

  localparam int ACK_TIMEOUT = 200;
  localparam int NB = `QDR_NUM_BANKS;

  logic                      qdr_clk = 1'b0;
  logic                      host_clk = 1'b0;
  logic                      qdr_rst;
  logic                      host_rst;
  logic                      host_en;
  qdr_bridge_pkg::host_cmd_t host_cmd;
  qdr_bridge_pkg::qdr_rsp_t  qdr_rsp [NB];
  qdr_bridge_pkg::qdr_req_t  qdr_req [NB];
  logic                      host_ack;
  logic [31:0]               host_rdata;
  logic                      read_strobe;

  // expected host words of the low 1 KB
  logic [31:0]   sb [256];
  logic          started = 1'b0;
  int            cur_bank = 0;
  int            errors = 0;
  int            accesses = 0;
  int            reads_issued = 0;
  int            ack_count = 0;
  int            strobe_count = 0;
  logic [NB-1:0] prev_req;
  logic [NB-1:0] prev_ack;
  logic [31:0]   rnd;
  logic [31:0]   addr;

  always #4 qdr_clk = ~qdr_clk;
  always #6 host_clk = ~host_clk;

  qdr_cpu_bridge UUT (
    .host_clk    (host_clk),
    .host_rst    (host_rst),
    .qdr_clk     (qdr_clk),
    .qdr_rst     (qdr_rst),
    .host_en     (host_en),
    .host_cmd    (host_cmd),
    .qdr_rsp     (qdr_rsp),
    .host_ack    (host_ack),
    .host_rdata  (host_rdata),
    .qdr_req     (qdr_req),
    .read_strobe (read_strobe)
  );

  for (genvar g = 0; g < NB; g++) begin : g_mem
    qdr_sram_model u_mem (
      .qdr_clk (qdr_clk),
      .qdr_rst (qdr_rst),
      .req     (qdr_req[g]),
      .rsp     (qdr_rsp[g])
    );
  end

  initial begin
    qdr_rst = 1'b1;
    repeat (5) @(negedge qdr_clk);
    qdr_rst = 1'b0;
  end

  // host side ack count and quiet bus before the first access
  always @(negedge host_clk) begin
    if (host_ack) begin
      ack_count++;
    end
    if (!host_rst && !started) begin
      assert (!host_ack) else begin
        errors++;
        $display("ERR %0t host_ack exp=0 got=%b", $time, host_ack);
      end
    end
  end

  always @(negedge qdr_clk) begin
    if (read_strobe) begin
      strobe_count++;
    end
    if (!qdr_rst && !started) begin
      assert (!read_strobe) else begin
        errors++;
        $display("ERR %0t read_strobe exp=0 got=%b", $time, read_strobe);
      end
      for (int b = 0; b < NB; b++) begin
        assert (qdr_req[b] == '0) else begin
          errors++;
          $display("ERR %0t qdr_req[%0d] exp=0 got=%h", $time, b, qdr_req[b]);
        end
      end
    end
  end

  // req only on the decoded bank and held until the bank acks
  always @(posedge qdr_clk) begin
    for (int b = 0; b < NB; b++) begin
      prev_req[b] <= qdr_req[b].req;
      prev_ack[b] <= qdr_rsp[b].ack;
      if (!qdr_rst && qdr_req[b].req) begin
        assert (b == cur_bank) else begin
          errors++;
          $display("ERR %0t qdr_req[%0d].req exp=0 got=1", $time, b);
        end
      end
      if (!qdr_rst && prev_req[b] && !prev_ack[b]) begin
        assert (qdr_req[b].req) else begin
          errors++;
          $display("ERR %0t qdr_req[%0d].req exp=1 got=0", $time, b);
        end
      end
    end
  end

  task automatic finish_run();
    $display("accesses=%0d reads=%0d acks=%0d strobes=%0d errors=%0d",
             accesses, reads_issued, ack_count, strobe_count, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  endtask

  task automatic wait_for_ack();
    int n;
    n = 0;
    while (!host_ack && n < ACK_TIMEOUT) begin
      @(negedge host_clk);
      n++;
    end
    if (!host_ack) begin
      errors++;
      $display("timeout at %0t: no host_ack within %0d host cycles", $time, ACK_TIMEOUT);
      finish_run();
    end
  endtask

  // one host access with scoreboard update or read compare
  task automatic host_access(input logic rnw, input logic [31:0] a,
                             input logic [31:0] wdata, input logic [3:0] be);
    int          acks_before;
    logic [31:0] exp_word;
    acks_before = ack_count;
    @(negedge host_clk);
    started       = 1'b1;
    cur_bank      = 32'(a[`QDR_BANK_LSB +: `QDR_BANK_BITS]);
    host_cmd.rnw  = rnw;
    host_cmd.addr = a;
    host_cmd.wdata = wdata;
    host_cmd.be   = be;
    host_en       = 1'b1;
    accesses++;
    if (rnw) begin
      reads_issued++;
    end
    @(negedge host_clk);
    host_en = 1'b0;
    wait_for_ack();
    exp_word = sb[a[9:2]];
    if (rnw) begin
      assert (host_rdata == exp_word) else begin
        errors++;
        $display("ERR %0t host_rdata addr=%h exp=%h got=%h", $time, a, exp_word, host_rdata);
      end
    end else begin
      // only enabled bytes change
      for (int i = 0; i < 4; i++) begin
        if (be[i]) begin
          sb[a[9:2]][i*8 +: 8] = wdata[i*8 +: 8];
        end
      end
    end
    // give a second host_ack room to show up before the counts are checked
    repeat (3) @(negedge host_clk);
    @(posedge host_clk);
    assert (ack_count == acks_before + 1) else begin
      errors++;
      $display("ERR %0t host_ack count exp=%0d got=%0d", $time, acks_before + 1, ack_count);
    end
    assert (strobe_count == reads_issued) else begin
      errors++;
      $display("ERR %0t read_strobe count exp=%0d got=%0d", $time, reads_issued, strobe_count);
    end
  endtask

  initial begin
    void'($urandom(32'h47f3));
    host_rst = 1'b1;
    host_en  = 1'b0;
    host_cmd = '0;
    for (int i = 0; i < 256; i++) begin
      sb[i] = '0;
    end
    repeat (5) @(negedge host_clk);
    host_rst = 1'b0;
    // idle stretch where the bus must stay quiet
    repeat (6) @(negedge host_clk);

    // full word write and read back in every slot of one burst
    for (int s = 0; s < 4; s++) begin
      rnd = $urandom();
      host_access(1'b0, 32'h40 + s*4, rnd, 4'hf);
      host_access(1'b1, 32'h40 + s*4, 32'h0, 4'hf);
    end

    // partial enables leave the neighbor words alone
    rnd = $urandom();
    host_access(1'b0, 32'h44, rnd, 4'b0101);
    rnd = $urandom();
    host_access(1'b0, 32'h48, rnd, 4'b1000);
    for (int s = 0; s < 4; s++) begin
      host_access(1'b1, 32'h40 + s*4, 32'h0, 4'hf);
    end

    // bit 4 flips the bank every access
    for (int i = 0; i < 8; i++) begin
      rnd  = $urandom();
      addr = 32'h100 + i*16 + (rnd & 32'hc);
      rnd  = $urandom();
      host_access(1'b0, addr, rnd, 4'hf);
      host_access(1'b1, addr, 32'h0, 4'hf);
    end
    for (int i = 0; i < 4; i++) begin
      for (int s = 0; s < 4; s++) begin
        host_access(1'b1, 32'h100 + i*16 + s*4, 32'h0, 4'hf);
      end
    end

    // random mix over the low 1 KB
    for (int n = 0; n < 40; n++) begin
      rnd  = $urandom();
      addr = {22'd0, rnd[8:1], 2'b00};
      host_access(rnd[0], addr, $urandom(), rnd[12:9]);
    end

    finish_run();
  end

endmodule

`default_nettype wire

// ==== hw/host_cmd_sync.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "qdr_bridge_params.svh"

module host_cmd_sync (
  input  wire logic                      host_clk,
  input  wire logic                      host_rst,
  input  wire logic                      qdr_clk,
  input  wire logic                      qdr_rst,
  input  wire logic                      host_en,
  input  wire qdr_bridge_pkg::host_cmd_t host_cmd,
  input  wire logic                      done,
  output logic                           host_ack,
  output qdr_bridge_pkg::host_cmd_t      cmd,
  output logic [`QDR_NUM_BANKS-1:0]      start,
  output logic                           cmd_active
);

  // host domain
  logic req_lvl;
  logic wait_clear;
  logic resp_r;
  logic resp_rr;

  // qdr domain
  logic req_r;
  logic req_rr;
  logic resp_lvl;
  logic [`QDR_BANK_BITS-1:0] bank;
  qdr_bridge_pkg::sync_state_e state;

  // host side request level
  // rises on host_en, drops once the response level comes back,
  // then host_ack fires after the response level has cleared again
  always_ff @(posedge host_clk) begin
    if (host_rst) begin
      req_lvl    <= 1'b0;
      wait_clear <= 1'b0;
      host_ack   <= 1'b0;
      resp_r     <= 1'b0;
      resp_rr    <= 1'b0;
    end else begin
      // two flop synchronizer for the response level
      resp_r   <= resp_lvl;
      resp_rr  <= resp_r;
      host_ack <= 1'b0;
      if (host_en) begin
        req_lvl    <= 1'b1;
        wait_clear <= 1'b0;
      end
      if (resp_rr) begin
        req_lvl    <= 1'b0;
        wait_clear <= 1'b1;
      end
      // response gone low, the qdr side is ready for the next access
      if (wait_clear && !resp_rr) begin
        wait_clear <= 1'b0;
        host_ack   <= 1'b1;
      end
    end
  end

  // qdr side handshake FSM
  always_ff @(posedge qdr_clk) begin
    if (qdr_rst) begin
      req_r    <= 1'b0;
      req_rr   <= 1'b0;
      resp_lvl <= 1'b0;
      cmd      <= '0;
      state    <= qdr_bridge_pkg::SYNC_IDLE;
    end else begin
      // two flop synchronizer for the request level
      req_r  <= req_lvl;
      req_rr <= req_r;
      case (state)
        qdr_bridge_pkg::SYNC_IDLE: begin
          // host holds host_cmd steady while its request is up
          if (req_rr) begin
            cmd   <= host_cmd;
            state <= qdr_bridge_pkg::SYNC_ISSUE;
          end
        end
        qdr_bridge_pkg::SYNC_ISSUE: begin
          // start pulse goes out during this state
          state <= qdr_bridge_pkg::SYNC_BUSY;
        end
        qdr_bridge_pkg::SYNC_BUSY: begin
          if (done) begin
            resp_lvl <= 1'b1;
          end
          // request dropped, release the response level
          if (!req_rr) begin
            resp_lvl <= 1'b0;
            state    <= qdr_bridge_pkg::SYNC_IDLE;
          end
        end
        default: begin
          state <= qdr_bridge_pkg::SYNC_IDLE;
        end
      endcase
    end
  end

  // bank field sits at the lowest burst address bits
  assign bank = cmd.addr[`QDR_BANK_LSB +: `QDR_BANK_BITS];

  // one hot start for the decoded bank, one cycle after the latch
  always_comb begin
    start = '0;
    if (state == qdr_bridge_pkg::SYNC_ISSUE) begin
      start[bank] = 1'b1;
    end
  end

  // merge block keeps its done level while this is high
  assign cmd_active = (state != qdr_bridge_pkg::SYNC_IDLE);

endmodule

`default_nettype wire

// ==== hw/qdr_bridge_params.svh ====
`ifndef QDR_BRIDGE_PARAMS_SVH
`define QDR_BRIDGE_PARAMS_SVH

// cycles from the grant (ack) cycle to the first read beat
// must be at least 2 for the grant tracking shift register
`define QDR_LATENCY 10

// number of identical qdr banks, one burst port each
`define QDR_NUM_BANKS 2

// width of the bank select field, log2 of the bank count
`define QDR_BANK_BITS 1

// host byte address bit where the bank field starts
// bit 4 is the lowest burst address bit
`define QDR_BANK_LSB 4

// burst address width, host address bits 31 down to 4
`define QDR_ADDR_W 28

`endif

// ==== hw/qdr_bridge_pkg.sv ====
`default_nettype none

`include "qdr_bridge_params.svh"

package qdr_bridge_pkg;

  // one host word access as latched in the qdr domain
  typedef struct packed {
    logic        rnw;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0]  be;
  } host_cmd_t;

  // request side of one qdr bank
  // d and be carry beat 0 in the ack cycle and beat 1 in the cycle after
  typedef struct packed {
    logic                   req;
    logic                   r;
    logic                   w;
    logic [`QDR_ADDR_W-1:0] addr;
    logic [71:0]            d;
    logic [7:0]             be;
  } qdr_req_t;

  // return side of one qdr bank
  typedef struct packed {
    logic        ack;
    logic [71:0] q;
  } qdr_rsp_t;

  // completion of one burst port, done is a single cycle pulse
  typedef struct packed {
    logic        done;
    logic        rd;
    logic [31:0] word;
  } port_done_t;

  // front end handshake states
  typedef enum logic [1:0] {
    SYNC_IDLE,
    SYNC_ISSUE,
    SYNC_BUSY
  } sync_state_e;

  // burst port states
  typedef enum logic [1:0] {
    BURST_IDLE,
    BURST_WAIT_GRANT,
    BURST_COLLECT,
    BURST_FINAL_BEAT
  } burst_state_e;

endpackage

`default_nettype wire

// ==== hw/qdr_burst_port.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "qdr_bridge_params.svh"

module qdr_burst_port (
  input  wire logic                      qdr_clk,
  input  wire logic                      qdr_rst,
  input  wire logic                      start,
  input  wire qdr_bridge_pkg::host_cmd_t cmd,
  input  wire qdr_bridge_pkg::qdr_rsp_t  rsp,
  output qdr_bridge_pkg::qdr_req_t       req,
  output qdr_bridge_pkg::port_done_t     done
);

  // four 36 bit slots, beat 0 is slots 0 and 1, beat 1 is slots 2 and 3
  logic [143:0] wr_buf;
  logic [35:0]  wr_slot;
  logic [1:0]   slot;
  logic [7:0]   lane_be;
  logic         second_beat;
  logic         done_q;
  logic         capture;
  logic [35:0]  rd_half;
  logic [31:0]  rd_word;
  logic [`QDR_LATENCY-1:0] grant_sr;
  qdr_bridge_pkg::burst_state_e state;

  // word index inside the 16 byte burst
  assign slot = cmd.addr[3:2];

  // pad each byte with a zero parity bit
  assign wr_slot = {1'b0, cmd.wdata[31:24], 1'b0, cmd.wdata[23:16],
                    1'b0, cmd.wdata[15:8],  1'b0, cmd.wdata[7:0]};

  // host byte enables land on the low or high half of the beat
  assign lane_be = slot[0] ? {cmd.be, 4'b0000} : {4'b0000, cmd.be};

  // buffer keeps earlier words of the burst so the whole burst can go out
  always_ff @(posedge qdr_clk) begin
    if (qdr_rst) begin
      wr_buf <= '0;
    end else if (start && !cmd.rnw) begin
      wr_buf[slot*36 +: 36] <= wr_slot;
    end
  end

  // bank request, held until the ack cycle
  always_comb begin
    req.req  = (state == qdr_bridge_pkg::BURST_WAIT_GRANT);
    req.r    = req.req & cmd.rnw;
    req.w    = req.req & ~cmd.rnw;
    req.addr = cmd.addr[31 -: `QDR_ADDR_W];
    // beat 0 in the ack cycle, beat 1 right after it
    req.d    = second_beat ? wr_buf[143:72] : wr_buf[71:0];
    // only the beat holding the addressed word gets enables
    req.be   = '0;
    if ((req.req && !slot[1]) || (second_beat && slot[1])) begin
      req.be = lane_be;
    end
  end

  // pick the half of the current beat holding the word
  assign rd_half = slot[0] ? rsp.q[71:36] : rsp.q[35:0];

  // read word is taken from beat 0 in collect, or from beat 1 in final_beat
  assign capture = cmd.rnw &&
                   ((state == qdr_bridge_pkg::BURST_COLLECT &&
                     grant_sr[`QDR_LATENCY-1] && !slot[1]) ||
                    state == qdr_bridge_pkg::BURST_FINAL_BEAT);

  always_ff @(posedge qdr_clk) begin
    if (qdr_rst) begin
      state       <= qdr_bridge_pkg::BURST_IDLE;
      second_beat <= 1'b0;
      done_q      <= 1'b0;
      grant_sr    <= '0;
    end else begin
      second_beat <= 1'b0;
      done_q      <= 1'b0;
      // top bit marks the cycle beat 0 comes back
      grant_sr    <= {grant_sr[`QDR_LATENCY-2:0], req.req & rsp.ack};
      case (state)
        qdr_bridge_pkg::BURST_IDLE: begin
          if (start) begin
            state <= qdr_bridge_pkg::BURST_WAIT_GRANT;
          end
        end
        qdr_bridge_pkg::BURST_WAIT_GRANT: begin
          if (rsp.ack) begin
            second_beat <= 1'b1;
            state       <= qdr_bridge_pkg::BURST_COLLECT;
          end
        end
        qdr_bridge_pkg::BURST_COLLECT: begin
          if (!cmd.rnw) begin
            // second write beat is on the bus now
            done_q <= 1'b1;
            state  <= qdr_bridge_pkg::BURST_IDLE;
          end else if (grant_sr[`QDR_LATENCY-1]) begin
            if (!slot[1]) begin
              done_q <= 1'b1;
              state  <= qdr_bridge_pkg::BURST_IDLE;
            end else begin
              // slots 2 and 3 arrive one cycle later
              state <= qdr_bridge_pkg::BURST_FINAL_BEAT;
            end
          end
        end
        qdr_bridge_pkg::BURST_FINAL_BEAT: begin
          done_q <= 1'b1;
          state  <= qdr_bridge_pkg::BURST_IDLE;
        end
        default: begin
          state <= qdr_bridge_pkg::BURST_IDLE;
        end
      endcase
    end
  end

  // strip the parity bits off the chosen half
  always_ff @(posedge qdr_clk) begin
    if (capture) begin
      rd_word <= {rd_half[34:27], rd_half[25:18], rd_half[16:9], rd_half[7:0]};
    end
  end

  always_comb begin
    done.done = done_q;
    done.rd   = cmd.rnw;
    done.word = rd_word;
  end

endmodule

`default_nettype wire

// ==== hw/qdr_cpu_bridge.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "qdr_bridge_params.svh"

module qdr_cpu_bridge (
  input  wire logic                      host_clk,
  input  wire logic                      host_rst,
  input  wire logic                      qdr_clk,
  input  wire logic                      qdr_rst,
  input  wire logic                      host_en,
  input  wire qdr_bridge_pkg::host_cmd_t host_cmd,
  input  wire qdr_bridge_pkg::qdr_rsp_t  qdr_rsp [`QDR_NUM_BANKS],
  output logic                           host_ack,
  output logic [31:0]                    host_rdata,
  output qdr_bridge_pkg::qdr_req_t       qdr_req [`QDR_NUM_BANKS],
  output logic                           read_strobe
);

  qdr_bridge_pkg::host_cmd_t  cmd;
  qdr_bridge_pkg::port_done_t port_done [`QDR_NUM_BANKS];
  logic [`QDR_NUM_BANKS-1:0]  start;
  logic                       cmd_active;
  logic                       merged_done;

  // clock crossing and bank decode
  host_cmd_sync u_sync (
    .host_clk   (host_clk),
    .host_rst   (host_rst),
    .qdr_clk    (qdr_clk),
    .qdr_rst    (qdr_rst),
    .host_en    (host_en),
    .host_cmd   (host_cmd),
    .done       (merged_done),
    .host_ack   (host_ack),
    .cmd        (cmd),
    .start      (start),
    .cmd_active (cmd_active)
  );

  // one burst port per bank, all share the latched command
  for (genvar g = 0; g < `QDR_NUM_BANKS; g++) begin : g_bank
    qdr_burst_port u_port (
      .qdr_clk (qdr_clk),
      .qdr_rst (qdr_rst),
      .start   (start[g]),
      .cmd     (cmd),
      .rsp     (qdr_rsp[g]),
      .req     (qdr_req[g]),
      .done    (port_done[g])
    );
  end

  qdr_resp_merge u_merge (
    .qdr_clk     (qdr_clk),
    .qdr_rst     (qdr_rst),
    .done_in     (port_done),
    .cmd_active  (cmd_active),
    .done        (merged_done),
    .read_word   (host_rdata),
    .read_strobe (read_strobe)
  );

endmodule

`default_nettype wire

// ==== hw/qdr_resp_merge.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "qdr_bridge_params.svh"

module qdr_resp_merge (
  input  wire logic                       qdr_clk,
  input  wire logic                       qdr_rst,
  input  wire qdr_bridge_pkg::port_done_t done_in [`QDR_NUM_BANKS],
  input  wire logic                       cmd_active,
  output logic                            done,
  output logic [31:0]                     read_word,
  output logic                            read_strobe
);

  logic        any_done;
  logic        any_rd;
  logic [31:0] sel_word;

  // at most one port completes per access, so a plain OR is enough
  always_comb begin
    any_done = 1'b0;
    any_rd   = 1'b0;
    sel_word = '0;
    for (int i = 0; i < `QDR_NUM_BANKS; i++) begin
      if (done_in[i].done) begin
        any_done = 1'b1;
        any_rd   = any_rd | done_in[i].rd;
        sel_word = sel_word | done_in[i].word;
      end
    end
  end

  always_ff @(posedge qdr_clk) begin
    if (qdr_rst) begin
      done        <= 1'b0;
      read_strobe <= 1'b0;
    end else begin
      read_strobe <= any_done & any_rd;
      // level stays up until the front end leaves busy
      if (!cmd_active) begin
        done <= 1'b0;
      end else if (any_done) begin
        done <= 1'b1;
      end
    end
  end

  // read data held until the next read completes
  always_ff @(posedge qdr_clk) begin
    if (any_done && any_rd) begin
      read_word <= sel_word;
    end
  end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build with Verilator, run, and pass only when the pass line shows up
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/1ns \
  --top-module tb_qdr_cpu_bridge -f verilog.f -o sim_tb &&
./obj_dir/sim_tb | tee /dev/stderr | grep "TESTBENCH PASSED" > /dev/null &&
echo "run_sim: pass" || { echo "run_sim: fail"; exit 1; }

// ==== verilog.f ====
+incdir+hw
hw/qdr_bridge_pkg.sv
hw/host_cmd_sync.sv
hw/qdr_burst_port.sv
hw/qdr_resp_merge.sv
hw/qdr_cpu_bridge.sv
dv/qdr_sram_model.sv
dv/tb_qdr_cpu_bridge.sv
